//--- source/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Address and bus geometry
`define FETCH_ADDR_W    32
`define FETCH_BUS_W     64

// First instruction fetched after reset
`define FETCH_RESET_PC  32'h0000_1000

// Fixed id on every read, single outstanding read
`define FETCH_AXI_ID    4'h1

// Instruction width and AR encodings for one 8-byte beat
`define FETCH_INST_W    32
`define FETCH_AR_SIZE   3'd3
`define FETCH_AR_BURST  2'b01

`endif

//--- source/fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA,
        FETCH_WAIT
    } fetch_state_e;

    // AR payload, valid and ready travel separately
    typedef struct packed {
        logic [3:0]                 id;
        logic [`FETCH_ADDR_W-1:0]   addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        logic [1:0]                 burst;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0]                 id;
        logic [`FETCH_BUS_W-1:0]    data;
        axi_resp_e                  resp;
        logic                       last;
    } axi_r_t;

    // What decode sees
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0]   pc;
        logic [`FETCH_INST_W-1:0]   inst;
        logic                       err;
    } ifid_t;

endpackage

//--- source/pc_gen.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module pc_gen (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        advance,
    input  logic                        redirect,
    input  logic [`FETCH_ADDR_W-1:0]    redirect_pc,
    output logic [`FETCH_ADDR_W-1:0]    fetch_pc
);

    logic [`FETCH_ADDR_W-1:0] pc_q;
    logic [`FETCH_ADDR_W-1:0] pc_next;

    // Redirect wins over sequential step
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (advance) begin
            pc_next = pc_q + `FETCH_ADDR_W'd4;
        end else begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `FETCH_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign fetch_pc = pc_q;

    // Targets come from outside, so alignment is not guaranteed locally
    pc_aligned_a: assert property (
        @(posedge clk) disable iff (reset)
        fetch_pc[1:0] == 2'b00
    );

endmodule

//--- source/fetch_ctrl.sv
`timescale 1ns/10ps

module fetch_ctrl (
    input  logic    clk,
    input  logic    reset,
    input  logic    redirect,
    input  logic    ar_done,
    input  logic    r_done,
    input  logic    r_err,
    input  logic    ifid_full,
    input  logic    ifid_drain,
    output logic    issue,
    output logic    r_ready,
    output logic    capture,
    output logic    advance
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::fetch_state_e state_next;

    logic kill;
    logic can_issue;
    logic in_flight;

    // Register empty now or emptied on this edge
    assign can_issue = !ifid_full || ifid_drain;
    assign in_flight = (state == fetch_pkg::FETCH_ADDR) || (state == fetch_pkg::FETCH_DATA);

    // No issue on a redirect edge since the PC is about to change
    assign issue = ((state == fetch_pkg::FETCH_IDLE) || (state == fetch_pkg::FETCH_WAIT))
                   && can_issue && !redirect;

    assign r_ready = (state == fetch_pkg::FETCH_DATA);

    // Killed reads still complete on the bus but are dropped here
    assign capture = r_done && !kill && !redirect;
    assign advance = capture;

    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::FETCH_IDLE,
            fetch_pkg::FETCH_WAIT: begin
                if (issue) begin
                    state_next = fetch_pkg::FETCH_ADDR;
                end else if (!ifid_full) begin
                    state_next = fetch_pkg::FETCH_IDLE;
                end
            end
            fetch_pkg::FETCH_ADDR: begin
                if (ar_done) begin
                    state_next = fetch_pkg::FETCH_DATA;
                end
            end
            fetch_pkg::FETCH_DATA: begin
                if (r_done) begin
                    state_next = capture ? fetch_pkg::FETCH_WAIT : fetch_pkg::FETCH_IDLE;
                end
            end
            default: state_next = fetch_pkg::FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch_pkg::FETCH_IDLE;
            kill  <= 1'b0;
        end else begin
            state <= state_next;
            if (r_done) begin
                kill <= 1'b0;
            end else if (redirect && in_flight) begin
                kill <= 1'b1;
            end
        end
    end

    // IF/ID must have room whenever a beat is written
    capture_room_a: assert property (
        @(posedge clk) disable iff (reset)
        capture |-> (!ifid_full || ifid_drain)
    );

    // Error flag only comes with a completed beat
    err_on_beat_a: assert property (
        @(posedge clk) disable iff (reset)
        r_err |-> (r_done && r_ready)
    );

endmodule

//--- source/axi_fetch_port.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module axi_fetch_port (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        issue,
    input  logic [`FETCH_ADDR_W-1:0]    fetch_pc,
    input  logic                        ar_ready,
    input  logic                        r_valid,
    input  fetch_pkg::axi_r_t           r,
    output fetch_pkg::axi_ar_t          ar,
    output logic                        ar_valid,
    output logic                        ar_done,
    output logic                        r_done,
    output logic [`FETCH_BUS_W-1:0]     beat,
    output logic                        r_err
);

    logic [`FETCH_ADDR_W-1:0] ar_addr;
    logic                     ar_pending;
    logic                     r_wait;

    // Beat aligned address, held until AR is accepted
    always_ff @(posedge clk) begin
        if (issue) begin
            ar_addr <= {fetch_pc[`FETCH_ADDR_W-1:3], 3'b000};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ar_pending <= 1'b0;
            r_wait     <= 1'b0;
        end else begin
            if (issue) begin
                ar_pending <= 1'b1;
            end else if (ar_done) begin
                ar_pending <= 1'b0;
            end
            if (ar_done) begin
                r_wait <= 1'b1;
            end else if (r_done) begin
                r_wait <= 1'b0;
            end
        end
    end

    assign ar_valid = ar_pending;
    assign ar_done  = ar_pending && ar_ready;

    assign ar.id    = `FETCH_AXI_ID;
    assign ar.addr  = ar_addr;
    assign ar.len   = 8'd0;
    assign ar.size  = `FETCH_AR_SIZE;
    assign ar.burst = `FETCH_AR_BURST;

    assign r_done = r_wait && r_valid;
    assign beat   = r.data;
    assign r_err  = r_done && ((r.resp == fetch_pkg::SLVERR) || (r.resp == fetch_pkg::DECERR));

    ar_stable_a: assert property (
        @(posedge clk) disable iff (reset)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar))
    );

    // Single beat reads, so the one beat is last and carries our id
    r_single_a: assert property (
        @(posedge clk) disable iff (reset)
        r_done |-> (r.last && (r.id == `FETCH_AXI_ID))
    );

endmodule

//--- source/if_id_reg.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module if_id_reg (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        capture,
    input  logic                        flush,
    input  logic [`FETCH_ADDR_W-1:0]    fetch_pc,
    input  logic [`FETCH_BUS_W-1:0]     beat,
    input  logic                        r_err,
    input  logic                        in_ready,
    input  logic                        stall,
    output fetch_pkg::ifid_t            out,
    output logic                        out_valid,
    output logic                        full,
    output logic                        drain
);

    logic                       valid;
    logic [`FETCH_ADDR_W-1:0]   pc_q;
    logic [`FETCH_BUS_W-1:0]    beat_q;
    logic                       err_q;

    // Decode takes the instruction
    assign drain = valid && in_ready && !stall;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (capture) begin
            valid <= 1'b1;
        end else if (drain) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pc_q   <= fetch_pc;
            beat_q <= beat;
            err_q  <= r_err;
        end
    end

    // Half of the beat picked by PC bit 2
    assign out.pc   = pc_q;
    assign out.inst = pc_q[2] ? beat_q[`FETCH_BUS_W-1:`FETCH_INST_W]
                              : beat_q[`FETCH_INST_W-1:0];
    assign out.err  = err_q;

    assign out_valid = valid;
    assign full      = valid;

    out_hold_a: assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !drain && !flush) |=> (out_valid && $stable(out))
    );

endmodule

//--- source/fetch_frontend.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module fetch_frontend (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        redirect,
    input  logic [`FETCH_ADDR_W-1:0]    redirect_pc,
    input  logic                        stall,
    input  logic                        in_ready,
    output fetch_pkg::ifid_t            out,
    output logic                        out_valid,
    output fetch_pkg::axi_ar_t          ar,
    output logic                        ar_valid,
    input  logic                        ar_ready,
    input  fetch_pkg::axi_r_t           r,
    input  logic                        r_valid,
    output logic                        r_ready
);

    logic [`FETCH_ADDR_W-1:0]   fetch_pc;
    logic [`FETCH_BUS_W-1:0]    beat;
    logic                       issue;
    logic                       capture;
    logic                       advance;
    logic                       ar_done;
    logic                       r_done;
    logic                       r_err;
    logic                       ifid_full;
    logic                       ifid_drain;

    pc_gen u_pc_gen (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_pc    (fetch_pc)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk        (clk),
        .reset      (reset),
        .redirect   (redirect),
        .ar_done    (ar_done),
        .r_done     (r_done),
        .r_err      (r_err),
        .ifid_full  (ifid_full),
        .ifid_drain (ifid_drain),
        .issue      (issue),
        .r_ready    (r_ready),
        .capture    (capture),
        .advance    (advance)
    );

    axi_fetch_port u_axi_fetch_port (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .fetch_pc (fetch_pc),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r        (r),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_done  (ar_done),
        .r_done   (r_done),
        .beat     (beat),
        .r_err    (r_err)
    );

    // Redirect doubles as the IF/ID flush
    if_id_reg u_if_id_reg (
        .clk       (clk),
        .reset     (reset),
        .capture   (capture),
        .flush     (redirect),
        .fetch_pc  (fetch_pc),
        .beat      (beat),
        .r_err     (r_err),
        .in_ready  (in_ready),
        .stall     (stall),
        .out       (out),
        .out_valid (out_valid),
        .full      (ifid_full),
        .drain     (ifid_drain)
    );

endmodule

//--- testbench/axi_rom_model.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module axi_rom_model (
    input  logic                    clk,
    input  logic                    reset,
    input  fetch_pkg::axi_ar_t      ar,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    output fetch_pkg::axi_r_t       r,
    output logic                    r_valid,
    input  logic                    r_ready
);

    integer seed = 49016;
    logic [`FETCH_ADDR_W-1:0] addr;

    function automatic logic [31:0] rom_word(input logic [31:0] byte_addr);
        return (byte_addr >> 2) * 32'h9E37_79B1 + 32'd1;
    endfunction

    // One read at a time with outputs changing on the falling edge
    task automatic serve_read();
        integer delay;
        delay = $random(seed) & 3;
        repeat (delay) @(negedge clk);
        ar_ready = 1'b1;
        addr = ar.addr;
        @(negedge clk);
        ar_ready = 1'b0;
        delay = $random(seed) & 3;
        repeat (delay) @(negedge clk);
        r_valid = 1'b1;
        r.id   = `FETCH_AXI_ID;
        r.data = {rom_word(addr + 32'd4), rom_word(addr)};
        r.resp = (addr >= 32'h2000 && addr <= 32'h20FF) ? fetch_pkg::SLVERR : fetch_pkg::OKAY;
        r.last = 1'b1;
        while (!r_ready) @(negedge clk);
        @(negedge clk);
        r_valid = 1'b0;
    endtask

    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        addr     = '0;
        @(negedge clk);
        forever begin
            if (!reset && ar_valid) begin
                serve_read();
            end else begin
                @(negedge clk);
            end
        end
    end

endmodule

//--- testbench/fetch_frontend_tb.sv
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module fetch_frontend_tb;

    localparam integer NUM_INSTR     = 1500;
    localparam integer WATCHDOG_CYC  = 2000 * 20;

    logic                       clk;
    logic                       reset;
    logic                       redirect;
    logic [`FETCH_ADDR_W-1:0]   redirect_pc;
    logic                       stall;
    logic                       in_ready;
    fetch_pkg::ifid_t           out;
    logic                       out_valid;
    fetch_pkg::axi_ar_t         ar;
    logic                       ar_valid;
    logic                       ar_ready;
    fetch_pkg::axi_r_t          r;
    logic                       r_valid;
    logic                       r_ready;

    integer seed = 49016;
    integer taken_count = 0;
    integer err_seen = 0;
    integer flight_redirects = 0;
    logic [31:0] exp_pc;

    fetch_frontend UUT (
        .clk(clk), .reset(reset), .redirect(redirect), .redirect_pc(redirect_pc),
        .stall(stall), .in_ready(in_ready), .out(out), .out_valid(out_valid),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready)
    );

    axi_rom_model u_rom (
        .clk(clk), .reset(reset), .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready)
    );

    // Expected {err, inst} for an instruction address
    function automatic logic [32:0] expected_fetch(input logic [31:0] pc);
        logic [31:0] word;
        logic        err;
        word = (pc >> 2) * 32'h9E37_79B1 + 32'd1;
        err  = (pc >= 32'h2000) && (pc <= 32'h20FF);
        return {err, word};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYC * 10);
        $display("Timeout: only %0d of %0d instructions reached decode", taken_count, NUM_INSTR);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    // Stimulus on the falling edge
    initial begin
        logic [31:0] rnd;
        reset       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b0;
        in_ready    = 1'b0;
        repeat (5) @(negedge clk);
        check_value("reset_out_valid", 64'd0, {63'd0, out_valid});
        check_value("reset_ar_valid", 64'd0, {63'd0, ar_valid});
        check_value("reset_r_ready", 64'd0, {63'd0, r_ready});
        reset = 1'b0;
        while (taken_count < NUM_INSTR) begin
            @(negedge clk);
            rnd = $random(seed);
            redirect = (rnd[5:0] < 6'd2);
            if (rnd[6]) begin
                redirect_pc = 32'h2000 + {24'd0, rnd[13:8], 2'b00};
            end else begin
                redirect_pc = 32'h1000 + {18'd0, rnd[23:12], 2'b00};
            end
            rnd = $random(seed);
            in_ready = (rnd[1:0] != 2'b00) && !redirect;
            stall    = (rnd[4:2] == 3'b000);
        end
        @(negedge clk);
        check_value("err_window_seen", 64'd1, {63'd0, err_seen > 0});
        check_value("redirect_in_flight_seen", 64'd1, {63'd0, flight_redirects > 0});
        $display("SIMULATION PASSED");
        $finish;
    end

    // Compare after the falling edge inputs settle, before the next rising edge
    initial begin
        logic                 held;
        logic                 ar_wait;
        logic                 ar_taken;
        logic                 flushed;
        fetch_pkg::ifid_t     prev_out;
        fetch_pkg::axi_ar_t   prev_ar;
        logic [32:0]          exp;
        held     = 1'b0;
        ar_wait  = 1'b0;
        ar_taken = 1'b0;
        flushed  = 1'b0;
        exp_pc   = `FETCH_RESET_PC;
        forever begin
            @(negedge clk);
            #1;
            if (!reset) begin
                if (held) begin
                    check_value("held_valid", 64'd1, {63'd0, out_valid});
                    check_value("held_out", prev_out[63:0], out[63:0]);
                    check_value("held_out_top", {63'd0, prev_out[64]}, {63'd0, out[64]});
                end
                if (flushed) begin
                    check_value("redirect_flush", 64'd0, {63'd0, out_valid});
                end
                if (ar_wait) begin
                    check_value("ar_valid_held", 64'd1, {63'd0, ar_valid});
                    check_value("ar_stable", {15'd0, prev_ar}, {15'd0, ar});
                end
                if (ar_taken) begin
                    check_value("r_ready_after_ar", 64'd1, {63'd0, r_ready});
                end
                if (ar_valid) begin
                    check_value("ar_len", 64'd0, {56'd0, ar.len});
                    check_value("ar_align", 64'd0, {61'd0, ar.addr[2:0]});
                    check_value("ar_size", 64'd3, {61'd0, ar.size});
                    check_value("ar_burst", 64'd1, {62'd0, ar.burst});
                    check_value("ar_id", {60'd0, `FETCH_AXI_ID}, {60'd0, ar.id});
                end
                if (redirect) begin
                    if (ar_valid || r_ready) begin
                        flight_redirects = flight_redirects + 1;
                    end
                    exp_pc = redirect_pc;
                end else if (out_valid && in_ready && !stall) begin
                    exp = expected_fetch(exp_pc);
                    check_value("taken_pc", {32'd0, exp_pc}, {32'd0, out.pc});
                    check_value("taken_inst", {32'd0, exp[31:0]}, {32'd0, out.inst});
                    check_value("taken_err", {63'd0, exp[32]}, {63'd0, out.err});
                    if (out.err) begin
                        err_seen = err_seen + 1;
                    end
                    exp_pc = exp_pc + 32'd4;
                    taken_count = taken_count + 1;
                end
                held     = out_valid && !(in_ready && !stall) && !redirect;
                prev_out = out;
                flushed  = redirect;
                ar_wait  = ar_valid && !ar_ready;
                ar_taken = ar_valid && ar_ready;
                prev_ar  = ar;
            end
        end
    end

endmodule

//--- fetch_frontend.f
+incdir+source
source/fetch_pkg.sv
source/pc_gen.sv
source/fetch_ctrl.sv
source/axi_fetch_port.sv
source/if_id_reg.sv
source/fetch_frontend.sv
testbench/axi_rom_model.sv
testbench/fetch_frontend_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := fetch_frontend_tb
FILELIST   := fetch_frontend.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)
PASS_TEXT  := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
